//--- src/cpu_subsystem_pkg.sv
// Shared types for the CPU subsystem
// Word, register index and byte enable types, ALU and class enums, opcodes

package cpu_subsystem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  be_t;

    // PASS_B forwards operand b for LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // Instruction classes seen by execute
    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_WFI,
        CLS_NOP
    } instr_class_e;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Full encoding of WFI
    localparam word_t INSTR_WFI = 32'h1050_0073;

    // Width of a word access in funct3
    localparam logic [2:0] F3_WORD = 3'b010;

endpackage

//--- src/cpu_fetch.sv
// Instruction fetch
// Program counter and OBI instruction port, one word per instruction

`timescale 1ns/1ps

module cpu_fetch
    import cpu_subsystem_pkg::*;
#(
    parameter word_t BOOT_ADDR = 32'h0000_0180
) (
    input  logic  clk_i,
    input  logic  reset_i,

    // Restart from the result stage
    input  logic  next_valid_i,
    input  word_t next_pc_i,

    // OBI instruction port
    output logic  instr_req_o,
    output word_t instr_addr_o,
    input  logic  instr_gnt_i,
    input  logic  instr_rvalid_i,
    input  word_t instr_rdata_i,

    // To decode
    output logic  instr_valid_o,
    output word_t instr_word_o,
    output word_t pc_o
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e state_q;
    word_t        pc_q;
    word_t        instr_word_q;
    logic         instr_valid_q;
    logic         started_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= FETCH_IDLE;
            pc_q          <= '0;
            instr_valid_q <= 1'b0;
            started_q     <= 1'b0;
        end else begin
            instr_valid_q <= 1'b0;
            case (state_q)
                FETCH_IDLE: begin
                    if (next_valid_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= FETCH_REQ;
                    end else if (!started_q) begin
                        // First fetch after reset
                        pc_q      <= BOOT_ADDR;
                        started_q <= 1'b1;
                        state_q   <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (instr_gnt_i) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (instr_rvalid_i) begin
                        instr_valid_q <= 1'b1;
                        state_q       <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    // Latch the returned instruction word
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH_WAIT && instr_rvalid_i) begin
            instr_word_q <= instr_rdata_i;
        end
    end

    assign instr_req_o   = (state_q == FETCH_REQ);
    assign instr_addr_o  = pc_q;
    assign instr_valid_o = instr_valid_q;
    assign instr_word_o  = instr_word_q;
    assign pc_o          = pc_q;

endmodule

//--- src/cpu_decode.sv
// Instruction decode
// Class, ALU operation, register indexes and sign-extended immediate

`timescale 1ns/1ps

module cpu_decode
    import cpu_subsystem_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,

    // From fetch
    input  logic         instr_valid_i,
    input  word_t        instr_word_i,
    input  word_t        pc_i,

    // To execute
    output logic         dec_valid_o,
    output instr_class_e cls_o,
    output alu_op_e      alu_op_o,
    output reg_idx_t     rd_o,
    output reg_idx_t     rs1_o,
    output reg_idx_t     rs2_o,
    output word_t        imm_o,
    output word_t        pc_o,
    output logic         branch_ne_o
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    word_t        imm_i_type;
    word_t        imm_s_type;
    word_t        imm_b_type;
    word_t        imm_u_type;
    word_t        imm_j_type;
    instr_class_e cls_d;
    alu_op_e      alu_op_d;
    word_t        imm_d;

    logic         dec_valid_q;

    assign opcode = instr_word_i[6:0];
    assign funct3 = instr_word_i[14:12];
    assign funct7 = instr_word_i[31:25];

    // Immediate formats
    assign imm_i_type = {{20{instr_word_i[31]}}, instr_word_i[31:20]};
    assign imm_s_type = {{20{instr_word_i[31]}}, instr_word_i[31:25], instr_word_i[11:7]};
    assign imm_b_type = {{19{instr_word_i[31]}}, instr_word_i[31], instr_word_i[7],
                         instr_word_i[30:25], instr_word_i[11:8], 1'b0};
    assign imm_u_type = {instr_word_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_word_i[31]}}, instr_word_i[31], instr_word_i[19:12],
                         instr_word_i[20], instr_word_i[30:21], 1'b0};

    always_comb begin
        cls_d    = CLS_NOP;
        alu_op_d = ALU_ADD;
        imm_d    = imm_i_type;
        case (opcode)
            OPC_OP: begin
                cls_d = CLS_ALU_REG;
                case (funct3)
                    3'b000:  alu_op_d = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op_d = ALU_XOR;
                    3'b110:  alu_op_d = ALU_OR;
                    3'b111:  alu_op_d = ALU_AND;
                    default: cls_d    = CLS_NOP;
                endcase
            end
            // Only ADDI among the immediate ops
            OPC_OP_IMM: if (funct3 == 3'b000) cls_d = CLS_ALU_IMM;
            OPC_LUI: begin
                cls_d    = CLS_ALU_IMM;
                alu_op_d = ALU_PASS_B;
                imm_d    = imm_u_type;
            end
            OPC_LOAD:  if (funct3 == F3_WORD) cls_d = CLS_LOAD;
            OPC_STORE: begin
                if (funct3 == F3_WORD) cls_d = CLS_STORE;
                imm_d = imm_s_type;
            end
            OPC_BRANCH: begin
                // BEQ and BNE only
                if (funct3[2:1] == 2'b00) cls_d = CLS_BRANCH;
                imm_d = imm_b_type;
            end
            OPC_JAL: begin
                cls_d = CLS_JAL;
                imm_d = imm_j_type;
            end
            OPC_SYSTEM: if (instr_word_i == INSTR_WFI) cls_d = CLS_WFI;
            default: cls_d = CLS_NOP;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= instr_valid_i;
        end
    end

    // Decoded fields stay stable until the next instruction arrives
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            cls_o       <= cls_d;
            alu_op_o    <= alu_op_d;
            rd_o        <= instr_word_i[11:7];
            rs1_o       <= instr_word_i[19:15];
            rs2_o       <= instr_word_i[24:20];
            imm_o       <= imm_d;
            pc_o        <= pc_i;
            branch_ne_o <= funct3[0];
        end
    end

    assign dec_valid_o = dec_valid_q;

endmodule

//--- src/cpu_execute.sv
// Execute stage
// ALU, branch compare and OBI data port for word loads and stores

`timescale 1ns/1ps

module cpu_execute
    import cpu_subsystem_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,

    // From decode
    input  logic         dec_valid_i,
    input  instr_class_e cls_i,
    input  alu_op_e      alu_op_i,
    input  reg_idx_t     rd_i,
    input  reg_idx_t     rs1_i,
    input  reg_idx_t     rs2_i,
    input  word_t        imm_i,
    input  word_t        pc_i,
    input  logic         branch_ne_i,

    // Register file read
    output reg_idx_t     rs1_idx_o,
    output reg_idx_t     rs2_idx_o,
    input  word_t        rs1_data_i,
    input  word_t        rs2_data_i,

    // OBI data port
    output logic         data_req_o,
    output word_t        data_addr_o,
    output logic         data_we_o,
    output be_t          data_be_o,
    output word_t        data_wdata_o,
    input  logic         data_gnt_i,
    input  logic         data_rvalid_i,
    input  word_t        data_rdata_i,

    // To result
    output logic         ex_done_o,
    output logic         wb_en_o,
    output reg_idx_t     wb_idx_o,
    output word_t        wb_data_o,
    output logic         redirect_o,
    output word_t        target_o,
    output logic         halt_o
);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_REQ,
        EX_WAIT
    } ex_state_e;

    ex_state_e state_q;
    logic      ex_done_q;
    word_t     op_b;
    word_t     alu_res;
    logic      taken;
    logic      is_mem;

    // Operands come straight from the decoded indexes
    assign rs1_idx_o = rs1_i;
    assign rs2_idx_o = rs2_i;

    assign op_b   = (cls_i == CLS_ALU_REG) ? rs2_data_i : imm_i;
    assign taken  = branch_ne_i ? (rs1_data_i != rs2_data_i) : (rs1_data_i == rs2_data_i);
    assign is_mem = (cls_i == CLS_LOAD) || (cls_i == CLS_STORE);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_res = rs1_data_i + op_b;
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= EX_IDLE;
            ex_done_q <= 1'b0;
        end else begin
            ex_done_q <= 1'b0;
            case (state_q)
                EX_IDLE: begin
                    if (dec_valid_i) begin
                        if (is_mem) state_q <= EX_REQ;
                        else ex_done_q <= 1'b1;
                    end
                end
                EX_REQ: if (data_gnt_i) state_q <= EX_WAIT;
                EX_WAIT: begin
                    if (data_rvalid_i) begin
                        ex_done_q <= 1'b1;
                        state_q   <= EX_IDLE;
                    end
                end
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    // Request payload and writeback results
    always_ff @(posedge clk_i) begin
        if (state_q == EX_IDLE && dec_valid_i) begin
            data_addr_o  <= rs1_data_i + imm_i;
            data_we_o    <= (cls_i == CLS_STORE);
            data_wdata_o <= rs2_data_i;
            wb_idx_o     <= rd_i;
            wb_en_o      <= 1'b0;
            wb_data_o    <= alu_res;
            redirect_o   <= 1'b0;
            target_o     <= pc_i + imm_i;
            halt_o       <= 1'b0;
            case (cls_i)
                CLS_ALU_REG, CLS_ALU_IMM: wb_en_o <= 1'b1;
                CLS_BRANCH:               redirect_o <= taken;
                CLS_JAL: begin
                    wb_en_o    <= 1'b1;
                    wb_data_o  <= pc_i + 32'd4;
                    redirect_o <= 1'b1;
                end
                CLS_WFI:                  halt_o <= 1'b1;
                default:                  wb_en_o <= 1'b0;
            endcase
        end else if (state_q == EX_WAIT && data_rvalid_i) begin
            // Loads write back the returned word
            wb_en_o   <= !data_we_o;
            wb_data_o <= data_rdata_i;
        end
    end

    assign data_req_o = (state_q == EX_REQ);
    assign data_be_o  = '1;
    assign ex_done_o  = ex_done_q;

endmodule

//--- src/cpu_result.sv
// Result stage
// Register file, writeback and next program counter selection

`timescale 1ns/1ps

module cpu_result
    import cpu_subsystem_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,

    input  word_t    pc_i,

    // From execute
    input  logic     ex_done_i,
    input  logic     wb_en_i,
    input  reg_idx_t wb_idx_i,
    input  word_t    wb_data_i,
    input  logic     redirect_i,
    input  word_t    target_i,
    input  logic     halt_i,

    // Operand reads for execute
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,

    // To fetch
    output logic     next_valid_o,
    output word_t    next_pc_o,
    output logic     core_sleep_o
);

    // x0 is not stored
    word_t regs_q [1:31];
    logic  next_valid_q;
    logic  sleep_q;

    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (ex_done_i && wb_en_i && wb_idx_i != '0) begin
            regs_q[wb_idx_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            next_valid_q <= 1'b0;
            sleep_q      <= 1'b0;
        end else begin
            next_valid_q <= ex_done_i && !halt_i;
            // Stays asleep until reset
            if (ex_done_i && halt_i) begin
                sleep_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_done_i) begin
            next_pc_o <= redirect_i ? target_i : pc_i + 32'd4;
        end
    end

    assign next_valid_o = next_valid_q;
    assign core_sleep_o = sleep_q;

endmodule

//--- src/cpu_subsystem.sv
// CPU subsystem top level
// Fetch, decode, execute and result stages on two OBI ports

`timescale 1ns/1ps

module cpu_subsystem
    import cpu_subsystem_pkg::*;
#(
    parameter word_t BOOT_ADDR = 32'h0000_0180
) (
    input  logic  clk_i,
    input  logic  reset_i,

    // Instruction memory port
    output logic  instr_req_o,
    output word_t instr_addr_o,
    input  logic  instr_gnt_i,
    input  logic  instr_rvalid_i,
    input  word_t instr_rdata_i,

    // Data memory port
    output logic  data_req_o,
    output word_t data_addr_o,
    output logic  data_we_o,
    output be_t   data_be_o,
    output word_t data_wdata_o,
    input  logic  data_gnt_i,
    input  logic  data_rvalid_i,
    input  word_t data_rdata_i,

    output logic  core_sleep_o
);

    logic         next_valid;
    word_t        next_pc;
    logic         instr_valid;
    word_t        instr_word;
    word_t        fetch_pc;

    logic         dec_valid;
    instr_class_e cls;
    alu_op_e      alu_op;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    word_t        imm;
    word_t        dec_pc;
    logic         branch_ne;

    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    word_t        rs1_data;
    word_t        rs2_data;

    logic         ex_done;
    logic         wb_en;
    reg_idx_t     wb_idx;
    word_t        wb_data;
    logic         redirect;
    word_t        target;
    logic         halt;

    cpu_fetch #(
        .BOOT_ADDR(BOOT_ADDR)
    ) fetch_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .next_valid_i  (next_valid),
        .next_pc_i     (next_pc),
        .instr_req_o   (instr_req_o),
        .instr_addr_o  (instr_addr_o),
        .instr_gnt_i   (instr_gnt_i),
        .instr_rvalid_i(instr_rvalid_i),
        .instr_rdata_i (instr_rdata_i),
        .instr_valid_o (instr_valid),
        .instr_word_o  (instr_word),
        .pc_o          (fetch_pc)
    );

    cpu_decode decode_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_valid_i(instr_valid),
        .instr_word_i (instr_word),
        .pc_i         (fetch_pc),
        .dec_valid_o  (dec_valid),
        .cls_o        (cls),
        .alu_op_o     (alu_op),
        .rd_o         (rd),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .imm_o        (imm),
        .pc_o         (dec_pc),
        .branch_ne_o  (branch_ne)
    );

    cpu_execute execute_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dec_valid_i  (dec_valid),
        .cls_i        (cls),
        .alu_op_i     (alu_op),
        .rd_i         (rd),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .imm_i        (imm),
        .pc_i         (dec_pc),
        .branch_ne_i  (branch_ne),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .data_req_o   (data_req_o),
        .data_addr_o  (data_addr_o),
        .data_we_o    (data_we_o),
        .data_be_o    (data_be_o),
        .data_wdata_o (data_wdata_o),
        .data_gnt_i   (data_gnt_i),
        .data_rvalid_i(data_rvalid_i),
        .data_rdata_i (data_rdata_i),
        .ex_done_o    (ex_done),
        .wb_en_o      (wb_en),
        .wb_idx_o     (wb_idx),
        .wb_data_o    (wb_data),
        .redirect_o   (redirect),
        .target_o     (target),
        .halt_o       (halt)
    );

    cpu_result result_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pc_i        (dec_pc),
        .ex_done_i   (ex_done),
        .wb_en_i     (wb_en),
        .wb_idx_i    (wb_idx),
        .wb_data_i   (wb_data),
        .redirect_i  (redirect),
        .target_i    (target),
        .halt_i      (halt),
        .rs1_idx_i   (rs1_idx),
        .rs2_idx_i   (rs2_idx),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .next_valid_o(next_valid),
        .next_pc_o   (next_pc),
        .core_sleep_o(core_sleep_o)
    );

endmodule

//--- verification/tb_cpu_subsystem.sv
// Testbench for the CPU subsystem
// OBI instruction and data memory models with random grant delays,
// golden file reader, fetch and store checks

`timescale 1ns/1ps

module tb_cpu_subsystem
    import cpu_subsystem_pkg::*;
();

    localparam word_t       BOOT_ADDR    = 32'h0000_0180;
    localparam int          MEM_WORDS    = 256;
    localparam word_t       SEED         = 32'd10067;
    localparam int          RUN_TIMEOUT  = 5000;
    localparam int          QUIET_CYCLES = 50;
    localparam string       GOLDEN_FILE  = "verification/cpu_subsystem_golden.txt";

    logic  clk;
    logic  reset;
    logic  instr_req;
    word_t instr_addr;
    logic  instr_gnt;
    logic  instr_rvalid;
    word_t instr_rdata;
    logic  data_req;
    word_t data_addr;
    logic  data_we;
    be_t   data_be;
    word_t data_wdata;
    logic  data_gnt;
    logic  data_rvalid;
    word_t data_rdata;
    logic  core_sleep;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    word_t exp_fetch[$];
    word_t exp_store_addr[$];
    word_t exp_store_data[$];

    word_t       rng_state = SEED;
    int unsigned instr_delay;
    int unsigned data_delay;
    logic        instr_pending;
    logic        data_pending;
    word_t       instr_rdata_q;
    word_t       data_rdata_q;

    cpu_subsystem #(
        .BOOT_ADDR(BOOT_ADDR)
    ) dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_req_o   (instr_req),
        .instr_addr_o  (instr_addr),
        .instr_gnt_i   (instr_gnt),
        .instr_rvalid_i(instr_rvalid),
        .instr_rdata_i (instr_rdata),
        .data_req_o    (data_req),
        .data_addr_o   (data_addr),
        .data_we_o     (data_we),
        .data_be_o     (data_be),
        .data_wdata_o  (data_wdata),
        .data_gnt_i    (data_gnt),
        .data_rvalid_i (data_rvalid),
        .data_rdata_i  (data_rdata),
        .core_sleep_o  (core_sleep)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Grant delay of 0 to 3 cycles
    task automatic draw_delay(output int unsigned delay);
        rng_state = xorshift(rng_state);
        delay = rng_state[1:0];
    endtask

    // Unwritten memory words follow their address
    function automatic word_t fill_word(input word_t addr);
        return addr ^ 32'hC3A5_0000;
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_with_failure();
    endtask

    task automatic check_fetch(input word_t addr);
        word_t exp;
        if (exp_fetch.size() == 0) begin
            report_error($sformatf("instruction fetch at %h beyond the expected list", addr));
        end else begin
            exp = exp_fetch.pop_front();
            if (addr !== exp) begin
                report_mismatch($sformatf("fetch address %h, expected %h", addr, exp));
            end
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        word_t exp_addr;
        word_t exp_data;
        if (exp_store_addr.size() == 0) begin
            report_error($sformatf("store to %h beyond the expected list", addr));
        end else begin
            exp_addr = exp_store_addr.pop_front();
            exp_data = exp_store_data.pop_front();
            if (addr !== exp_addr || data !== exp_data) begin
                report_mismatch($sformatf("store %h to %h, expected %h to %h",
                                          data, addr, exp_data, exp_addr));
            end
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    rc;
        int    cnt;
        string line;
        byte   tag;
        word_t a;
        word_t b;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_error("cannot open the golden file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() > 0) begin
                    tag = line.getc(0);
                    case (tag)
                        "P": begin
                            rc = $sscanf(line, "P %h %h", a, b);
                            imem[a[9:2]] = b;
                        end
                        "D": begin
                            rc = $sscanf(line, "D %h %h", a, b);
                            dmem[a[9:2]] = b;
                        end
                        // A run of consecutive fetch addresses
                        "F": begin
                            rc = $sscanf(line, "F %h %d", a, cnt);
                            for (int i = 0; i < cnt; i++) begin
                                exp_fetch.push_back(a + 4 * i);
                            end
                        end
                        "S": begin
                            rc = $sscanf(line, "S %h %h", a, b);
                            exp_store_addr.push_back(a);
                            exp_store_data.push_back(b);
                        end
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Both memory models answer on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            instr_gnt    = 1'b0;
            instr_rvalid = 1'b0;
            if (instr_pending) begin
                instr_rvalid  = 1'b1;
                instr_rdata   = instr_rdata_q;
                instr_pending = 1'b0;
            end else if (instr_req) begin
                if (instr_delay == 0) begin
                    check_fetch(instr_addr);
                    instr_gnt     = 1'b1;
                    instr_pending = 1'b1;
                    instr_rdata_q = imem[instr_addr[9:2]];
                    draw_delay(instr_delay);
                end else begin
                    instr_delay--;
                end
            end

            data_gnt    = 1'b0;
            data_rvalid = 1'b0;
            if (data_pending) begin
                data_rvalid  = 1'b1;
                data_rdata   = data_rdata_q;
                data_pending = 1'b0;
            end else if (data_req) begin
                if (data_delay == 0) begin
                    if (data_be !== 4'hF) begin
                        report_error("data request without all byte enables set");
                    end
                    if (data_we) begin
                        check_store(data_addr, data_wdata);
                        dmem[data_addr[9:2]] = data_wdata;
                    end
                    data_gnt     = 1'b1;
                    data_pending = 1'b1;
                    data_rdata_q = dmem[data_addr[9:2]];
                    draw_delay(data_delay);
                end else begin
                    data_delay--;
                end
            end
        end
    end

    initial begin
        int cycles;
        reset         = 1'b1;
        instr_gnt     = 1'b0;
        instr_rvalid  = 1'b0;
        instr_rdata   = '0;
        data_gnt      = 1'b0;
        data_rvalid   = 1'b0;
        data_rdata    = '0;
        instr_pending = 1'b0;
        data_pending  = 1'b0;
        instr_rdata_q = '0;
        data_rdata_q  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = fill_word(i * 4);
            dmem[i] = fill_word(i * 4);
        end
        load_golden();
        draw_delay(instr_delay);
        draw_delay(data_delay);

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (core_sleep !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end

        if (core_sleep !== 1'b1) begin
            report_error("timeout waiting for core_sleep_o after the program");
        end else begin
            // Core must stay quiet after WFI
            cycles = 0;
            while (instr_req !== 1'b1 && cycles < QUIET_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (instr_req === 1'b1) begin
                report_error("instruction request seen after WFI");
            end else if (exp_fetch.size() != 0) begin
                report_error($sformatf("%0d expected fetches never happened", exp_fetch.size()));
            end else if (exp_store_addr.size() != 0) begin
                report_error($sformatf("%0d expected stores never happened",
                                       exp_store_addr.size()));
            end else begin
                $display("Verification passed");
                $finish;
            end
        end
    end

endmodule

//--- verification/cpu_subsystem_golden.txt
# P addr word = program word, D addr word = initial data word, all hex
# F addr count = run of consecutive fetch addresses, count in decimal
# S addr data = expected store in order, hex
P 00000180 10000093 addi x1, x0, 0x100
P 00000184 01900113 addi x2, x0, 25
P 00000188 ff900193 addi x3, x0, -7
P 0000018c 00310233 add  x4, x2, x3
P 00000190 0040a023 sw   x4, 0(x1)
P 00000194 403102b3 sub  x5, x2, x3
P 00000198 0050a223 sw   x5, 4(x1)
P 0000019c abcde337 lui  x6, 0xabcde
P 000001a0 002343b3 xor  x7, x6, x2
P 000001a4 0070a423 sw   x7, 8(x1)
P 000001a8 0023f433 and  x8, x7, x2
P 000001ac 0080a623 sw   x8, 12(x1)
P 000001b0 002264b3 or   x9, x4, x2
P 000001b4 0090a823 sw   x9, 16(x1)
P 000001b8 0400a503 lw   x10, 0x40(x1)
P 000001bc 0440a583 lw   x11, 0x44(x1)
P 000001c0 00b50633 add  x12, x10, x11
P 000001c4 00c0aa23 sw   x12, 20(x1)
P 000001c8 00a0ac23 sw   x10, 24(x1)
P 000001cc 00310463 beq  x2, x3, +8 not taken
P 000001d0 00311663 bne  x2, x3, +12 taken
P 000001d4 00100693 addi x13, x0, 1 skipped
P 000001d8 00200693 addi x13, x0, 2 skipped
P 000001dc 00420463 beq  x4, x4, +8 taken
P 000001e0 00300693 addi x13, x0, 3 skipped
P 000001e4 00a51463 bne  x10, x10, +8 not taken
P 000001e8 00c0076f jal  x14, +12
P 000001ec 00400693 addi x13, x0, 4 skipped
P 000001f0 00500693 addi x13, x0, 5 skipped
P 000001f4 00e0ae23 sw   x14, 28(x1)
P 000001f8 02d0a023 sw   x13, 32(x1)
P 000001fc 03700013 addi x0, x0, 55
P 00000200 00210033 add  x0, x2, x2
P 00000204 0200a223 sw   x0, 36(x1)
P 00000208 10500073 wfi
D 00000140 12345678
D 00000144 0f0f0f0f
F 00000180 21
F 000001dc 1
F 000001e4 2
F 000001f4 6
S 00000100 00000012
S 00000104 00000020
S 00000108 abcde019
S 0000010c 00000019
S 00000110 0000001b
S 00000114 21436587
S 00000118 12345678
S 0000011c 000001ec
S 00000120 00000000
S 00000124 00000000

//--- cpu_subsystem.f
src/cpu_subsystem_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_result.sv
src/cpu_subsystem.sv
verification/tb_cpu_subsystem.sv

//--- Bender.yml
package:
  name: cpu_subsystem

sources:
  - files:
      - src/cpu_subsystem_pkg.sv
      - src/cpu_fetch.sv
      - src/cpu_decode.sv
      - src/cpu_execute.sv
      - src/cpu_result.sv
      - src/cpu_subsystem.sv
  - target: test
    files:
      - verification/tb_cpu_subsystem.sv
